// File: run.sh
#!/usr/bin/env bash
# Build and run the microcode sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module ucode_seq_tb -f sources.f -o ucode_seq_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/ucode_seq_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test OK" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

// File: sim/ucode_seq_assert.sv
`timescale 1ns/1ps

module ucode_seq_assert #(
    parameter int RENAME_CREDITS = 4,
    parameter int CRED_W         = 3
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [CRED_W-1:0] credits,
    input  logic              state,
    input  logic              out_valid,
    input  uop_pkg::t_uinstr  out_uop
);

    // FSM encoding, FETCH is the only non-idle state
    localparam logic ST_FETCH = 1'b1;

    credits_bounded: assert property (@(posedge clk) disable iff (reset)
        credits <= CRED_W'(RENAME_CREDITS))
        else $error("rename credit count above its limit");

    issue_needs_credit: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> $past(credits) != '0)
        else $error("micro-op issued with no rename credit left");

    idle_after_eom: assert property (@(posedge clk) disable iff (reset)
        (state != ST_FETCH && $past(state) == ST_FETCH && !$past(reset))
        |-> (out_valid && out_uop.eom))
        else $error("FSM left FETCH without issuing an eom row");

endmodule

// File: sim/ucode_seq_checker.sv
`timescale 1ns/1ps

module ucode_seq_checker #(
    parameter int RENAME_CREDITS = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  uop_pkg::t_uinstr in_uop,
    input  logic             in_credit,
    input  logic             out_valid,
    input  uop_pkg::t_uinstr out_uop,
    input  logic             credit_return,
    input  logic             drained,
    output int               error_count,
    output int               pending_count
);

    uop_pkg::t_uinstr exp_q [$];
    bit               ucode_q [$];
    uop_pkg::t_uinstr exp_uop;
    bit               exp_ucode;
    string            test_name;
    int               accepted;
    int               credit_pulses;
    int               outstanding;
    bit               seen_input;

    // Last row of the entry that holds r, -1 outside all entries
    function automatic int entry_last(input int r, input int base, input int len);
        return (r >= base && r < base + len) ? base + len - 1 : -1;
    endfunction

    function automatic uop_pkg::t_uinstr rom_row(input int r);
        uop_pkg::t_uinstr row;
        int               last;
        row  = '0;
        last = entry_last(r, int'(ucode_cfg_pkg::ROM_ENT_MUL), ucode_cfg_pkg::ROM_LEN_MUL);
        if (last < 0) begin
            last = entry_last(r, int'(ucode_cfg_pkg::ROM_ENT_DIV), ucode_cfg_pkg::ROM_LEN_DIV);
        end
        if (last < 0) begin
            last = entry_last(r, int'(ucode_cfg_pkg::ROM_ENT_FENCE), ucode_cfg_pkg::ROM_LEN_FENCE);
        end
        if (last < 0) begin
            row.opcode = uop_pkg::OP_EBREAK;
            row.eom    = 1'b1;
        end else begin
            row.opcode = uop_pkg::OP_ADDI;
            row.rd     = 5'(r);
            row.imm    = 12'(256 + r);
            row.eom    = (r == last);
        end
        return row;
    endfunction

    // Expected output list of one input micro-op
    function automatic void expand_uop(input uop_pkg::t_uinstr u);
        uop_pkg::t_uinstr row;
        int               r;
        bit               done;
        if (!u.trap_to_ucode) begin
            exp_q.push_back(u);
            ucode_q.push_back(1'b0);
        end else begin
            r    = int'(u.rom_addr);
            done = 1'b0;
            for (int n = 0; n < ucode_cfg_pkg::ROM_ROWS && !done; n++) begin
                row     = rom_row(r);
                row.tag = u.tag;
                exp_q.push_back(row);
                ucode_q.push_back(1'b1);
                done = row.eom;
                r    = (r + 1) % ucode_cfg_pkg::ROM_ROWS;
            end
        end
    endfunction

    always @(posedge clk) begin
        if (!seen_input && (out_valid === 1'b1 || in_credit === 1'b1)) begin
            error_count++;
            $display("Output activity before the first input micro-op at %0t", $time);
        end
        if (!reset) begin
            if (in_valid) begin
                seen_input = 1'b1;
                accepted++;
                expand_uop(in_uop);
            end
            if (in_credit) begin
                credit_pulses++;
            end
            if (credit_return) begin
                outstanding--;
            end
            if (out_valid) begin
                outstanding++;
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("Unexpected micro-op on the rename port, tag %0d", out_uop.tag);
                end else begin
                    exp_uop   = exp_q.pop_front();
                    exp_ucode = ucode_q.pop_front();
                    test_name = exp_ucode ? "ucode_expand" : "passthrough";
                    if (out_uop !== exp_uop) begin
                        error_count++;
                        $display("FAILED %s: expected %h, actual %h", test_name, exp_uop, out_uop);
                    end
                end
            end
            if (outstanding > RENAME_CREDITS) begin
                error_count++;
                $display("Rename holds %0d micro-ops, more than its %0d credits",
                         outstanding, RENAME_CREDITS);
            end
            if (drained) begin
                if (credit_pulses != accepted) begin
                    error_count++;
                    $display("FAILED in_credit_count: expected %0d, actual %0d",
                             accepted, credit_pulses);
                end
            end
        end
        pending_count = exp_q.size();
    end

endmodule

// File: sim/ucode_seq_tb.sv
`timescale 1ns/1ps

module ucode_seq_tb;

    localparam int FIFO_DEPTH     = 4;
    localparam int RENAME_CREDITS = 4;
    localparam int NUM_UOPS       = 300;
    localparam int STALL_CYCLES   = 30;
    localparam int WAIT_LIMIT     = 2000;

    logic             clk;
    logic             reset;
    logic             in_valid;
    uop_pkg::t_uinstr in_uop;
    logic             in_credit;
    logic             out_valid;
    uop_pkg::t_uinstr out_uop;
    logic             credit_return = 1'b0;
    logic             drained;

    int  seed;
    int  cycle;
    int  sent_count;
    int  credit_back;
    int  timeout_count;
    int  chk_errors;
    int  chk_pending;
    bit  stall;
    int  return_due [$];

    ucode_cfg_pkg::t_rom_addr unused_rows [4];

    ucode_seq_top #(
        .FIFO_DEPTH     (FIFO_DEPTH),
        .RENAME_CREDITS (RENAME_CREDITS)
    ) dut_i (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_uop        (in_uop),
        .in_credit     (in_credit),
        .out_valid     (out_valid),
        .out_uop       (out_uop),
        .credit_return (credit_return)
    );

    ucode_seq_checker #(
        .RENAME_CREDITS (RENAME_CREDITS)
    ) checker_i (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_uop        (in_uop),
        .in_credit     (in_credit),
        .out_valid     (out_valid),
        .out_uop       (out_uop),
        .credit_return (credit_return),
        .drained       (drained),
        .error_count   (chk_errors),
        .pending_count (chk_pending)
    );

    bind ucode_fsm ucode_seq_assert #(
        .RENAME_CREDITS (RENAME_CREDITS),
        .CRED_W         (CRED_W)
    ) assert_i (
        .clk       (clk),
        .reset     (reset),
        .credits   (credits),
        .state     (state),
        .out_valid (out_valid),
        .out_uop   (out_uop)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic uop_pkg::t_uinstr make_uop(input int idx);
        uop_pkg::t_uinstr u;
        u        = '0;
        u.opcode = 8'(rand_below(256));
        u.rd     = 5'(rand_below(32));
        u.imm    = 12'(rand_below(4096));
        u.tag    = 8'(idx);
        if (rand_below(4) == 0) begin
            u.trap_to_ucode = 1'b1;
            case (rand_below(4))
                0:       u.rom_addr = ucode_cfg_pkg::ROM_ENT_MUL;
                1:       u.rom_addr = ucode_cfg_pkg::ROM_ENT_DIV;
                2:       u.rom_addr = ucode_cfg_pkg::ROM_ENT_FENCE;
                default: u.rom_addr = unused_rows[rand_below(4)];
            endcase
        end else begin
            u.rom_addr = 5'(rand_below(32));
        end
        return u;
    endfunction

    // Count decode credits and schedule rename returns
    always @(posedge clk) begin
        cycle++;
        if (in_credit === 1'b1) begin
            credit_back++;
        end
        if (out_valid === 1'b1) begin
            return_due.push_back(cycle + rand_below(6));
        end
    end

    always @(negedge clk) begin
        credit_return = 1'b0;
        if (!stall && return_due.size() > 0 && return_due[0] <= cycle) begin
            credit_return = 1'b1;
            void'(return_due.pop_front());
        end
    end

    task automatic send_uops();
        int waited;
        bit ready;
        for (int i = 0; i < NUM_UOPS; i++) begin
            @(negedge clk);
            in_valid = 1'b0;
            waited   = 0;
            ready    = (FIFO_DEPTH + credit_back - sent_count > 0) && rand_below(4) != 0;
            while (!ready && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
                ready = (FIFO_DEPTH + credit_back - sent_count > 0) && rand_below(4) != 0;
            end
            if (!ready) begin
                timeout_count++;
                $display("Timeout: decode got no credit back for micro-op %0d", i);
                break;
            end
            in_valid = 1'b1;
            in_uop   = make_uop(i);
            sent_count++;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // Rename withholds every credit for a while
    task automatic stall_rename();
        int waited;
        waited = 0;
        while (sent_count < NUM_UOPS / 2 && waited < 4 * WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (sent_count < NUM_UOPS / 2) begin
            timeout_count++;
            $display("Timeout: half of the micro-ops were never sent");
        end else begin
            stall = 1'b1;
            repeat (STALL_CYCLES) @(posedge clk);
            stall = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (chk_pending != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (chk_pending != 0) begin
            timeout_count++;
            $display("Timeout: sequencer did not drain, %0d micro-ops missing", chk_pending);
        end
    endtask

    initial begin
        seed        = 32'h36b1;
        unused_rows = '{5'd0, 5'd9, 5'd17, 5'd31};
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_uop      = '0;
        drained     = 1'b0;
        stall       = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        fork
            send_uops();
            stall_rename();
        join
        wait_drain();
        @(negedge clk);
        drained = 1'b1;
        @(negedge clk);
        drained = 1'b0;
        repeat (2) @(negedge clk);
        $display("Errors: %0d compare, %0d timeout", chk_errors, timeout_count);
        if (chk_errors == 0 && timeout_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
src/ucode_cfg_pkg.sv
src/uop_pkg.sv
src/uop_fifo.sv
src/upc_counter.sv
src/ucode_rom.sv
src/ucode_fsm.sv
src/ucode_seq_top.sv
sim/ucode_seq_assert.sv
sim/ucode_seq_checker.sv
sim/ucode_seq_tb.sv

// File: src/ucode_cfg_pkg.sv
package ucode_cfg_pkg;

    // ROM geometry
    localparam int ROM_ROWS   = 32;
    localparam int ROM_ADDR_W = $clog2(ROM_ROWS);

    typedef logic [ROM_ADDR_W-1:0] t_rom_addr;

    // Entry points of the macro sequences
    localparam t_rom_addr ROM_ENT_MUL   = 5'd4;
    localparam t_rom_addr ROM_ENT_DIV   = 5'd12;
    localparam t_rom_addr ROM_ENT_FENCE = 5'd20;

    // Rows per sequence, last row carries eom
    localparam int ROM_LEN_MUL   = 3;
    localparam int ROM_LEN_DIV   = 1;
    localparam int ROM_LEN_FENCE = 2;

endpackage

// File: src/ucode_fsm.sv
`timescale 1ns/1ps

module ucode_fsm #(
    parameter int RENAME_CREDITS = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             head_valid,
    input  uop_pkg::t_uinstr head_uop,
    input  uop_pkg::t_uinstr rom_uop,
    input  logic             credit_return,
    output logic             pop,
    output logic             upc_load,
    output logic             upc_advance,
    output logic             out_valid,
    output uop_pkg::t_uinstr out_uop
);

    localparam int CRED_W = $clog2(RENAME_CREDITS + 1);

    typedef enum logic {
        ST_IDLE,
        ST_FETCH
    } t_state;

    t_state state;
    t_state state_nxt;

    logic [CRED_W-1:0]         credits;
    logic                      has_credit;
    logic                      issue;
    uop_pkg::t_uinstr          issue_uop;
    logic [uop_pkg::TAG_W-1:0] trap_tag;

    assign has_credit = (credits != '0);

    always_comb begin
        state_nxt   = state;
        pop         = 1'b0;
        upc_load    = 1'b0;
        upc_advance = 1'b0;
        issue       = 1'b0;
        issue_uop   = head_uop;
        case (state)
            ST_IDLE: begin
                if (head_valid && has_credit) begin
                    pop = 1'b1;
                    // Trapping micro-op is consumed, not issued
                    if (head_uop.trap_to_ucode) begin
                        upc_load  = 1'b1;
                        state_nxt = ST_FETCH;
                    end else begin
                        issue = 1'b1;
                    end
                end
            end
            ST_FETCH: begin
                if (has_credit) begin
                    issue         = 1'b1;
                    upc_advance   = 1'b1;
                    issue_uop     = rom_uop;
                    issue_uop.tag = trap_tag;
                    if (rom_uop.eom) begin
                        state_nxt = ST_IDLE;
                    end
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    // Tag of the macro being expanded
    always_ff @(posedge clk) begin
        if (upc_load) begin
            trap_tag <= head_uop.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            out_uop <= issue_uop;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            credits   <= CRED_W'(RENAME_CREDITS);
            out_valid <= 1'b0;
        end else begin
            state     <= state_nxt;
            // spend and return can land in the same cycle
            credits   <= credits + CRED_W'(credit_return) - CRED_W'(issue);
            out_valid <= issue;
        end
    end

endmodule

// File: src/ucode_rom.sv
`timescale 1ns/1ps

module ucode_rom (
    input  ucode_cfg_pkg::t_rom_addr upc,
    output uop_pkg::t_uinstr         rom_uop
);

    localparam int NUM_ENT = 3;

    localparam ucode_cfg_pkg::t_rom_addr ENT_ADDR [NUM_ENT] = '{
        ucode_cfg_pkg::ROM_ENT_MUL,
        ucode_cfg_pkg::ROM_ENT_DIV,
        ucode_cfg_pkg::ROM_ENT_FENCE
    };

    localparam int ENT_LEN [NUM_ENT] = '{
        ucode_cfg_pkg::ROM_LEN_MUL,
        ucode_cfg_pkg::ROM_LEN_DIV,
        ucode_cfg_pkg::ROM_LEN_FENCE
    };

    uop_pkg::t_uinstr rom [ucode_cfg_pkg::ROM_ROWS];

    // Unused rows trap out with a single EBREAK
    function automatic uop_pkg::t_uinstr f_ebreak_row();
        uop_pkg::t_uinstr u;
        u        = '0;
        u.opcode = uop_pkg::OP_EBREAK;
        u.eom    = 1'b1;
        return u;
    endfunction

    function automatic uop_pkg::t_uinstr f_addi_row(input int row, input logic last);
        uop_pkg::t_uinstr u;
        u        = '0;
        u.opcode = uop_pkg::OP_ADDI;
        u.rd     = uop_pkg::REG_W'(row);
        u.imm    = uop_pkg::IMM_W'(256 + row);
        u.eom    = last;
        return u;
    endfunction

    always_comb begin
        int row;
        for (int r = 0; r < ucode_cfg_pkg::ROM_ROWS; r++) begin
            rom[r] = f_ebreak_row();
        end
        // Entry sequences overwrite the default rows
        for (int e = 0; e < NUM_ENT; e++) begin
            for (int i = 0; i < ENT_LEN[e]; i++) begin
                row = int'(ENT_ADDR[e]) + i;
                rom[ucode_cfg_pkg::t_rom_addr'(row)] = f_addi_row(row, i == ENT_LEN[e] - 1);
            end
        end
    end

    assign rom_uop = rom[upc];

endmodule

// File: src/ucode_seq_top.sv
`timescale 1ns/1ps

module ucode_seq_top #(
    parameter int FIFO_DEPTH     = 4,
    parameter int RENAME_CREDITS = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  uop_pkg::t_uinstr in_uop,
    output logic             in_credit,
    output logic             out_valid,
    output uop_pkg::t_uinstr out_uop,
    input  logic             credit_return
);

    logic                     head_valid;
    uop_pkg::t_uinstr         head_uop;
    logic                     pop;
    logic                     upc_load;
    logic                     upc_advance;
    ucode_cfg_pkg::t_rom_addr upc;
    uop_pkg::t_uinstr         rom_uop;

    // Input buffer from decode
    uop_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_uop     (in_uop),
        .pop        (pop),
        .head_valid (head_valid),
        .head_uop   (head_uop),
        .in_credit  (in_credit)
    );

    ucode_fsm #(
        .RENAME_CREDITS (RENAME_CREDITS)
    ) fsm_i (
        .clk           (clk),
        .reset         (reset),
        .head_valid    (head_valid),
        .head_uop      (head_uop),
        .rom_uop       (rom_uop),
        .credit_return (credit_return),
        .pop           (pop),
        .upc_load      (upc_load),
        .upc_advance   (upc_advance),
        .out_valid     (out_valid),
        .out_uop       (out_uop)
    );

    // Entry address comes straight from the buffer head
    upc_counter upc_i (
        .clk         (clk),
        .reset       (reset),
        .upc_load    (upc_load),
        .upc_advance (upc_advance),
        .load_addr   (head_uop.rom_addr),
        .upc         (upc)
    );

    ucode_rom rom_i (
        .upc     (upc),
        .rom_uop (rom_uop)
    );

endmodule

// File: src/uop_fifo.sv
`timescale 1ns/1ps

module uop_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  uop_pkg::t_uinstr  in_uop,
    input  logic              pop,
    output logic              head_valid,
    output uop_pkg::t_uinstr  head_uop,
    output logic              in_credit
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    uop_pkg::t_uinstr mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_pop;

    assign head_valid = (count != '0);
    assign head_uop   = mem[rd_ptr];

    // Ignore a pop request on an empty buffer
    assign do_pop = pop & head_valid;

    // Upstream credits keep the buffer from overflowing
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_uop;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            count     <= count + (PTR_W + 1)'(in_valid) - (PTR_W + 1)'(do_pop);
            // one credit back to decode per entry freed
            in_credit <= do_pop;
        end
    end

endmodule

// File: src/uop_pkg.sv
package uop_pkg;

    // Field widths
    localparam int OPCODE_W = 8;
    localparam int REG_W    = 5;
    localparam int IMM_W    = 12;
    localparam int TAG_W    = 8;

    // Opcodes used by the sequencer and the ROM
    localparam logic [OPCODE_W-1:0] OP_ADDI   = 8'h13;
    localparam logic [OPCODE_W-1:0] OP_EBREAK = 8'h73;

    // Decoded micro-op, 40 bits
    typedef struct packed {
        logic [OPCODE_W-1:0]      opcode;
        logic [REG_W-1:0]         rd;
        logic [IMM_W-1:0]         imm;
        // tracking id from decode
        logic [TAG_W-1:0]         tag;
        logic                     trap_to_ucode;
        ucode_cfg_pkg::t_rom_addr rom_addr;
        // end of macro sequence
        logic                     eom;
    } t_uinstr;

endpackage

// File: src/upc_counter.sv
`timescale 1ns/1ps

module upc_counter (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     upc_load,
    input  logic                     upc_advance,
    input  ucode_cfg_pkg::t_rom_addr load_addr,
    output ucode_cfg_pkg::t_rom_addr upc
);

    ucode_cfg_pkg::t_rom_addr upc_nxt;

    // Load wins over advance
    always_comb begin
        upc_nxt = upc;
        if (upc_load) begin
            upc_nxt = load_addr;
        end else if (upc_advance) begin
            upc_nxt = upc + ucode_cfg_pkg::t_rom_addr'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            upc <= '0;
        end else begin
            upc <= upc_nxt;
        end
    end

endmodule
